// File: rtl/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int ARF_DEPTH = 32;
    localparam int ROB_DEPTH = 64;
    localparam int ROB_LIMIT = 60; // alloc still allowed at this occupancy

    localparam int ARF_ID_W  = $clog2(ARF_DEPTH);
    localparam int ROB_ID_W  = $clog2(ROB_DEPTH);
    localparam int ROB_CNT_W = ROB_ID_W + 1; // needs to reach ROB_DEPTH itself
    localparam int ENTRY_W   = ROB_ID_W + 1;
    localparam int CHECK_BIT = ENTRY_W - 1;  // msb of a rat entry
    localparam int WORD_W    = 32;

    // architectural register id
    typedef logic [ARF_ID_W-1:0] arf_id_t;

    // rob id and occupancy
    typedef logic [ROB_ID_W-1:0]  rob_id_t;
    typedef logic [ROB_CNT_W-1:0] rob_cnt_t;

    // check bit on top, rob id below
    typedef logic [ENTRY_W-1:0] rat_entry_t;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_W-1:0] pc_t;

endpackage

`default_nettype wire

// File: rtl/rename_if.sv
`timescale 1ns/1ps
`default_nettype none

// rename stage <-> speculative rat
interface rename_if import rename_pkg::*; ();

    arf_id_t    [3:0] rarid;     // source ids, two per slot
    arf_id_t    [1:0] warid;     // destination ids
    logic       [1:0] we;
    rat_entry_t [1:0] new_entry;
    rat_entry_t [3:0] rdata;     // comb from rarid

    modport stage (
        output rarid, warid, we, new_entry,
        input  rdata
    );

    modport tbl (
        input  rarid, warid, we, new_entry,
        output rdata
    );

endinterface

`default_nettype wire

// File: rtl/alloc_if.sv
`timescale 1ns/1ps
`default_nettype none

interface alloc_if import rename_pkg::*; ();

    logic [1:0] issue;     // per slot
    rob_id_t    ptr;       // next free rob id
    logic       available;

    modport stage (
        output issue,
        input  ptr, available
    );

    modport alloc (
        input  issue,
        output ptr, available
    );

endinterface

`default_nettype wire

// File: rtl/rob_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module rob_alloc import rename_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       c_flush_i,
    input  logic [1:0] c_retire_i,
    alloc_if.alloc     a
);

    rob_cnt_t   cnt_q;
    rob_cnt_t   cnt_d;
    rob_id_t    ptr_q;
    logic       avail_q;
    logic [1:0] n_issue;
    logic [1:0] n_retire;

    assign n_issue  = {1'b0, a.issue[0]} + {1'b0, a.issue[1]};
    assign n_retire = {1'b0, c_retire_i[0]} + {1'b0, c_retire_i[1]};
    assign cnt_d    = cnt_q + rob_cnt_t'(n_issue) - rob_cnt_t'(n_retire);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q   <= '0;
            ptr_q   <= '0;
            avail_q <= 1'b1;
        end else if (c_flush_i) begin
            cnt_q   <= '0;
            ptr_q   <= '0;
            avail_q <= 1'b1;
        end else begin
            cnt_q   <= cnt_d;
            ptr_q   <= ptr_q + rob_id_t'(n_issue); // wraps at 64
            avail_q <= (cnt_q <= rob_cnt_t'(ROB_LIMIT)); // one cycle late
        end
    end

    assign a.ptr       = ptr_q;
    assign a.available = avail_q;

    // limit plus one cycle of slack keeps us inside the rob
    a_occ_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        cnt_q <= rob_cnt_t'(ROB_DEPTH));

endmodule

`default_nettype wire

// File: rtl/spec_rat.sv
`timescale 1ns/1ps
`default_nettype none

module spec_rat import rename_pkg::*; (
    input  logic clk,
    input  logic rst_n_i,
    input  logic c_flush_i,
    rename_if.tbl t
);

    rat_entry_t map_q [ARF_DEPTH];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < ARF_DEPTH; k++) begin
                map_q[k] <= '0;
            end
        end else if (c_flush_i) begin
            // all entries fall back to the committed mapping
            for (int k = 0; k < ARF_DEPTH; k++) begin
                map_q[k] <= '0;
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (t.we[w]) begin
                    map_q[t.warid[w]] <= t.new_entry[w]; // slot 1 last, wins
                end
            end
        end
    end

    for (genvar i = 0; i < 4; i++) begin : g_rd
        assign t.rdata[i] = map_q[t.rarid[i]];
    end

endmodule

`default_nettype wire

// File: rtl/regfile_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module regfile_fwd import rename_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int R_PORTS    = 4
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                clr_i,
    input  arf_id_t [R_PORTS-1:0]               raddr_i,
    output logic    [R_PORTS-1:0][DATA_WIDTH-1:0] rdata_o,
    input  logic    [1:0]                       we_i,
    input  arf_id_t [1:0]                       waddr_i,
    input  logic    [1:0][DATA_WIDTH-1:0]       wdata_i
);

    logic [DATA_WIDTH-1:0] mem_q [ARF_DEPTH];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < ARF_DEPTH; k++) begin
                mem_q[k] <= '0;
            end
        end else if (clr_i) begin
            for (int k = 0; k < ARF_DEPTH; k++) begin
                mem_q[k] <= '0;
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (we_i[w]) begin
                    mem_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // bypass this cycle's writes, port 1 checked last
    always_comb begin
        for (int p = 0; p < R_PORTS; p++) begin
            rdata_o[p] = mem_q[raddr_i[p]];
            for (int w = 0; w < 2; w++) begin
                if (we_i[w] && (waddr_i[w] == raddr_i[p])) begin
                    rdata_o[p] = wdata_i[w];
                end
            end
        end
    end

    // r0 must stay zero for every reader
    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(we_i[0] && waddr_i[0] == '0) && !(we_i[1] && waddr_i[1] == '0));

endmodule

`default_nettype wire

// File: rtl/rename_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rename_stage import rename_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                c_flush_i,
    input  logic                d_valid_i,
    output logic                d_ready_o,
    input  logic       [1:0]    d_r_valid_i,
    input  arf_id_t    [3:0]    d_rarid_i,
    input  arf_id_t    [1:0]    d_warid_i,
    input  logic       [1:0]    d_w_reg_i,
    input  logic       [3:0]    d_reg_need_i,
    input  pc_t        [1:0]    d_pc_i,
    input  word_t      [1:0]    d_imm_i,
    input  logic                p_ready_i,
    rename_if.stage             r,
    alloc_if.stage              a,
    input  rat_entry_t [5:0]    cr_rdata_i,  // [1:0] dests, [5:2] sources
    input  word_t      [3:0]    arf_rdata_i,
    input  logic       [1:0]    c_retire_i,
    input  logic       [1:0]    c_w_valid_i,
    input  arf_id_t    [1:0]    c_arf_id_i,
    input  rob_id_t    [1:0]    c_rob_id_i,
    input  logic       [1:0]    c_w_check_i,
    output logic       [1:0]    c_we_o,
    output arf_id_t    [1:0]    c_waddr_o,
    output rat_entry_t [1:0]    c_entry_o,
    output logic       [1:0]    p_r_valid_o,
    output logic       [1:0]    p_w_reg_o,
    output arf_id_t    [1:0]    p_areg_o,
    output rob_id_t    [1:0]    p_preg_o,
    output rob_id_t    [3:0]    p_src_preg_o,
    output logic       [1:0]    p_check_o,
    output word_t      [3:0]    p_arf_data_o,
    output logic       [3:0]    p_data_valid_o,
    output pc_t        [1:0]    p_pc_o,
    output word_t      [1:0]    p_imm_o
);

    logic       [1:0] issue;
    rob_id_t    [1:0] preg;
    rat_entry_t [1:0] new_entry;
    logic       [1:0] spec_we;
    logic       [3:0] bypass;
    rat_entry_t [3:0] src_entry;
    logic       [3:0] ready;

    assign d_ready_o = a.available & ~c_flush_i & p_ready_i;
    assign issue     = d_r_valid_i & {2{d_valid_i & d_ready_o}};
    assign a.issue   = issue;

    // slot 1 only takes ptr+1 when slot 0 also goes
    assign preg[0] = a.ptr;
    assign preg[1] = issue[0] ? a.ptr + 1'b1 : a.ptr;

    for (genvar i = 0; i < 2; i++) begin : g_dst
        assign new_entry[i] = {~cr_rdata_i[i][CHECK_BIT], preg[i]}; // flip committed check
        assign spec_we[i]   = issue[i] & d_w_reg_i[i] & (d_warid_i[i] != '0);
    end

    assign r.rarid     = d_rarid_i;
    assign r.warid     = d_warid_i;
    assign r.we        = spec_we;
    assign r.new_entry = new_entry;

    for (genvar i = 0; i < 4; i++) begin : g_src
        if (i >= 2) begin : g_slot1
            assign bypass[i] = spec_we[0] & (d_rarid_i[i] == d_warid_i[0]);
        end else begin : g_slot0
            assign bypass[i] = 1'b0;
        end
        assign src_entry[i] = bypass[i] ? new_entry[0] : r.rdata[i];
        // matching spec and commit entries mean the arf holds the value
        assign ready[i] = ~bypass[i]
                        & (~d_reg_need_i[i] | (src_entry[i] == cr_rdata_i[i+2]));
    end

    for (genvar i = 0; i < 2; i++) begin : g_ret
        assign c_we_o[i]    = c_retire_i[i] & c_w_valid_i[i] & (c_arf_id_i[i] != '0);
        assign c_waddr_o[i] = c_arf_id_i[i];
        assign c_entry_o[i] = {c_w_check_i[i], c_rob_id_i[i]};
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            p_r_valid_o    <= '0;
            p_w_reg_o      <= '0;
            p_areg_o       <= '0;
            p_preg_o       <= '0;
            p_src_preg_o   <= '0;
            p_check_o      <= '0;
            p_arf_data_o   <= '0;
            p_data_valid_o <= '0;
            p_pc_o         <= '0;
            p_imm_o        <= '0;
        end else if (c_flush_i) begin
            p_r_valid_o    <= '0;
            p_w_reg_o      <= '0;
            p_areg_o       <= '0;
            p_preg_o       <= '0;
            p_src_preg_o   <= '0;
            p_check_o      <= '0;
            p_arf_data_o   <= '0;
            p_data_valid_o <= '0;
            p_pc_o         <= '0;
            p_imm_o        <= '0;
        end else if (p_ready_i) begin
            p_r_valid_o    <= issue; // holes when decode stalls
            p_w_reg_o      <= d_w_reg_i;
            p_areg_o       <= d_warid_i;
            p_preg_o       <= preg;
            for (int k = 0; k < 4; k++) begin
                p_src_preg_o[k] <= src_entry[k][ROB_ID_W-1:0];
            end
            p_check_o      <= {new_entry[1][CHECK_BIT], new_entry[0][CHECK_BIT]};
            p_arf_data_o   <= arf_rdata_i;
            p_data_valid_o <= ready;
            p_pc_o         <= d_pc_i;
            p_imm_o        <= d_imm_i;
        end
    end

    a_no_issue_on_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
        c_flush_i |-> (a.issue == 2'b00));

endmodule

`default_nettype wire

// File: rtl/rename_top.sv
`timescale 1ns/1ps
`default_nettype none

module rename_top import rename_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                c_flush_i,
    input  logic                d_valid_i,
    output logic                d_ready_o,
    input  logic       [1:0]    d_r_valid_i,
    input  arf_id_t    [3:0]    d_rarid_i,
    input  arf_id_t    [1:0]    d_warid_i,
    input  logic       [1:0]    d_w_reg_i,
    input  logic       [3:0]    d_reg_need_i,
    input  pc_t        [1:0]    d_pc_i,
    input  word_t      [1:0]    d_imm_i,
    input  logic                p_ready_i,
    input  logic       [1:0]    c_retire_i,
    input  logic       [1:0]    c_w_valid_i,
    input  arf_id_t    [1:0]    c_arf_id_i,
    input  rob_id_t    [1:0]    c_rob_id_i,
    input  logic       [1:0]    c_w_check_i,
    input  word_t      [1:0]    c_data_i,
    output logic       [1:0]    p_r_valid_o,
    output logic       [1:0]    p_w_reg_o,
    output arf_id_t    [1:0]    p_areg_o,
    output rob_id_t    [1:0]    p_preg_o,
    output rob_id_t    [3:0]    p_src_preg_o,
    output logic       [1:0]    p_check_o,
    output word_t      [3:0]    p_arf_data_o,
    output logic       [3:0]    p_data_valid_o,
    output pc_t        [1:0]    p_pc_o,
    output word_t      [1:0]    p_imm_o
);

    rename_if rif ();
    alloc_if  aif ();

    rat_entry_t [5:0] cr_rdata;
    word_t      [3:0] arf_rdata;
    logic       [1:0] c_we;
    arf_id_t    [1:0] c_waddr;
    rat_entry_t [1:0] c_entry;

    rename_stage u_rename_stage (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .c_flush_i      (c_flush_i),
        .d_valid_i      (d_valid_i),
        .d_ready_o      (d_ready_o),
        .d_r_valid_i    (d_r_valid_i),
        .d_rarid_i      (d_rarid_i),
        .d_warid_i      (d_warid_i),
        .d_w_reg_i      (d_w_reg_i),
        .d_reg_need_i   (d_reg_need_i),
        .d_pc_i         (d_pc_i),
        .d_imm_i        (d_imm_i),
        .p_ready_i      (p_ready_i),
        .r              (rif.stage),
        .a              (aif.stage),
        .cr_rdata_i     (cr_rdata),
        .arf_rdata_i    (arf_rdata),
        .c_retire_i     (c_retire_i),
        .c_w_valid_i    (c_w_valid_i),
        .c_arf_id_i     (c_arf_id_i),
        .c_rob_id_i     (c_rob_id_i),
        .c_w_check_i    (c_w_check_i),
        .c_we_o         (c_we),
        .c_waddr_o      (c_waddr),
        .c_entry_o      (c_entry),
        .p_r_valid_o    (p_r_valid_o),
        .p_w_reg_o      (p_w_reg_o),
        .p_areg_o       (p_areg_o),
        .p_preg_o       (p_preg_o),
        .p_src_preg_o   (p_src_preg_o),
        .p_check_o      (p_check_o),
        .p_arf_data_o   (p_arf_data_o),
        .p_data_valid_o (p_data_valid_o),
        .p_pc_o         (p_pc_o),
        .p_imm_o        (p_imm_o)
    );

    spec_rat u_spec_rat (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .c_flush_i (c_flush_i),
        .t         (rif.tbl)
    );

    rob_alloc u_rob_alloc (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .c_flush_i  (c_flush_i),
        .c_retire_i (c_retire_i),
        .a          (aif.alloc)
    );

    // sources plus both destinations, dests on the low ports
    regfile_fwd #(
        .DATA_WIDTH (ENTRY_W),
        .R_PORTS    (6)
    ) u_commit_rat (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clr_i   (c_flush_i),
        .raddr_i ({rif.rarid, rif.warid}),
        .rdata_o (cr_rdata),
        .we_i    (c_we),
        .waddr_i (c_waddr),
        .wdata_i (c_entry)
    );

    // committed values survive a flush
    regfile_fwd #(
        .DATA_WIDTH (WORD_W),
        .R_PORTS    (4)
    ) u_arf (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clr_i   (1'b0),
        .raddr_i (rif.rarid),
        .rdata_o (arf_rdata),
        .we_i    (c_we),
        .waddr_i (c_waddr),
        .wdata_i (c_data_i)
    );

endmodule

`default_nettype wire

// File: sim/tb_rename_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rename_top import rename_pkg::*; ();

    localparam int TMO = 20; // cycles to wait for decode handshake

    logic clk;
    logic rst_n_i;
    logic c_flush_i;
    logic d_valid_i;
    logic d_ready_o;
    logic p_ready_i;
    logic [1:0] d_r_valid_i;
    logic [1:0] d_w_reg_i;
    logic [3:0] d_reg_need_i;
    arf_id_t [3:0] d_rarid_i;
    arf_id_t [1:0] d_warid_i;
    pc_t [1:0] d_pc_i;
    word_t [1:0] d_imm_i;
    logic [1:0] c_retire_i;
    logic [1:0] c_w_valid_i;
    logic [1:0] c_w_check_i;
    arf_id_t [1:0] c_arf_id_i;
    rob_id_t [1:0] c_rob_id_i;
    word_t [1:0] c_data_i;
    logic [1:0] p_r_valid_o;
    logic [1:0] p_w_reg_o;
    logic [1:0] p_check_o;
    logic [3:0] p_data_valid_o;
    arf_id_t [1:0] p_areg_o;
    rob_id_t [1:0] p_preg_o;
    rob_id_t [3:0] p_src_preg_o;
    word_t [3:0] p_arf_data_o;
    pc_t [1:0] p_pc_o;
    word_t [1:0] p_imm_o;

    // reference model of the tables
    rat_entry_t spec_m [ARF_DEPTH];
    rat_entry_t commit_m [ARF_DEPTH];
    word_t arf_m [ARF_DEPTH];
    rob_id_t ptr_m;
    int occ_m;
    logic avail_m;
    logic exp_ready;

    logic [1:0] exp_r_valid, exp_w_reg, exp_check;
    logic [3:0] exp_dvalid;
    arf_id_t [1:0] exp_areg;
    rob_id_t [1:0] exp_preg;
    rob_id_t [3:0] exp_src;
    word_t [3:0] exp_data;
    pc_t [1:0] exp_pc;
    word_t [1:0] exp_imm;

    // model scratch
    logic t_go, t_byp;
    logic [1:0] t_iss, t_wr;
    logic [3:0] t_rdy;
    rob_id_t [1:0] t_pr;
    rob_id_t [3:0] t_src;
    rat_entry_t [1:0] t_ent;
    rat_entry_t t_cr, t_se;
    word_t [3:0] t_dat;

    integer seed;
    int errors;
    int err_mark;
    int n_tests;
    int n;
    logic ok;

    rename_top u_rename_top (.*);

    always #20 clk = ~clk;

    assign exp_ready = avail_m & ~c_flush_i & p_ready_i;

    // committed entry as seen this cycle, retire writes forwarded
    function automatic rat_entry_t cr_rd(input arf_id_t id);
        rat_entry_t v;
        v = commit_m[id];
        for (int w = 0; w < 2; w++) begin
            if (c_retire_i[w] && c_w_valid_i[w] && c_arf_id_i[w] != '0 && c_arf_id_i[w] == id) begin
                v = {c_w_check_i[w], c_rob_id_i[w]};
            end
        end
        return v;
    endfunction

    function automatic word_t arf_rd(input arf_id_t id);
        word_t v;
        v = arf_m[id];
        for (int w = 0; w < 2; w++) begin
            if (c_retire_i[w] && c_w_valid_i[w] && c_arf_id_i[w] != '0 && c_arf_id_i[w] == id) begin
                v = c_data_i[w];
            end
        end
        return v;
    endfunction

    task automatic clear_expected();
        exp_r_valid <= '0;
        exp_w_reg   <= '0;
        exp_check   <= '0;
        exp_dvalid  <= '0;
        exp_areg    <= '0;
        exp_preg    <= '0;
        exp_src     <= '0;
        exp_data    <= '0;
        exp_pc      <= '0;
        exp_imm     <= '0;
    endtask

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < ARF_DEPTH; k++) begin
                spec_m[k]   <= '0;
                commit_m[k] <= '0;
                arf_m[k]    <= '0;
            end
            ptr_m   <= '0;
            occ_m   <= 0;
            avail_m <= 1'b1;
            clear_expected();
        end else begin
            t_go    = avail_m && !c_flush_i && p_ready_i && d_valid_i;
            t_iss   = d_r_valid_i & {2{t_go}};
            t_pr[0] = ptr_m;
            t_pr[1] = t_iss[0] ? ptr_m + 1'b1 : ptr_m; // second issuing slot
            for (int i = 0; i < 2; i++) begin
                t_cr     = cr_rd(d_warid_i[i]);
                t_ent[i] = {~t_cr[CHECK_BIT], t_pr[i]};
                t_wr[i]  = t_iss[i] && d_w_reg_i[i] && d_warid_i[i] != '0;
            end
            for (int s = 0; s < 4; s++) begin
                t_byp    = (s >= 2) && t_wr[0] && (d_rarid_i[s] == d_warid_i[0]);
                t_se     = t_byp ? t_ent[0] : spec_m[d_rarid_i[s]];
                t_src[s] = t_se[ROB_ID_W-1:0];
                t_rdy[s] = !t_byp && (!d_reg_need_i[s] || t_se == cr_rd(d_rarid_i[s]));
                t_dat[s] = arf_rd(d_rarid_i[s]);
            end
            for (int w = 0; w < 2; w++) begin
                if (c_retire_i[w] && c_w_valid_i[w] && c_arf_id_i[w] != '0) begin
                    commit_m[c_arf_id_i[w]] <= {c_w_check_i[w], c_rob_id_i[w]};
                    arf_m[c_arf_id_i[w]]    <= c_data_i[w];
                end
            end
            if (c_flush_i) begin
                for (int k = 0; k < ARF_DEPTH; k++) begin
                    spec_m[k]   <= '0;
                    commit_m[k] <= '0; // arf keeps its values
                end
                ptr_m   <= '0;
                occ_m   <= 0;
                avail_m <= 1'b1;
                clear_expected();
            end else begin
                for (int i = 0; i < 2; i++) begin
                    if (t_wr[i]) begin
                        spec_m[d_warid_i[i]] <= t_ent[i];
                    end
                end
                ptr_m   <= t_pr[1] + t_iss[1];
                occ_m   <= occ_m + t_iss[0] + t_iss[1] - c_retire_i[0] - c_retire_i[1];
                avail_m <= (occ_m <= ROB_LIMIT);
                if (p_ready_i) begin
                    exp_r_valid <= t_iss;
                    exp_w_reg   <= d_w_reg_i;
                    exp_areg    <= d_warid_i;
                    exp_preg    <= t_pr;
                    exp_src     <= t_src;
                    exp_check   <= {t_ent[1][CHECK_BIT], t_ent[0][CHECK_BIT]};
                    exp_data    <= t_dat;
                    exp_dvalid  <= t_rdy;
                    exp_pc      <= d_pc_i;
                    exp_imm     <= d_imm_i;
                end
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                   input logic [127:0] got_v);
        errors++;
        $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp_v, got_v);
    endtask

    a_r_valid: assert property (@(posedge clk) disable iff (!rst_n_i) p_r_valid_o == exp_r_valid)
        else report_mismatch("p_r_valid_o", $sampled(exp_r_valid), $sampled(p_r_valid_o));
    a_w_reg: assert property (@(posedge clk) disable iff (!rst_n_i) p_w_reg_o == exp_w_reg)
        else report_mismatch("p_w_reg_o", $sampled(exp_w_reg), $sampled(p_w_reg_o));
    a_areg: assert property (@(posedge clk) disable iff (!rst_n_i) p_areg_o == exp_areg)
        else report_mismatch("p_areg_o", $sampled(exp_areg), $sampled(p_areg_o));
    a_preg: assert property (@(posedge clk) disable iff (!rst_n_i) p_preg_o == exp_preg)
        else report_mismatch("p_preg_o", $sampled(exp_preg), $sampled(p_preg_o));
    a_src: assert property (@(posedge clk) disable iff (!rst_n_i) p_src_preg_o == exp_src)
        else report_mismatch("p_src_preg_o", $sampled(exp_src), $sampled(p_src_preg_o));
    a_check: assert property (@(posedge clk) disable iff (!rst_n_i) p_check_o == exp_check)
        else report_mismatch("p_check_o", $sampled(exp_check), $sampled(p_check_o));
    a_data: assert property (@(posedge clk) disable iff (!rst_n_i) p_arf_data_o == exp_data)
        else report_mismatch("p_arf_data_o", $sampled(exp_data), $sampled(p_arf_data_o));
    a_dvalid: assert property (@(posedge clk) disable iff (!rst_n_i) p_data_valid_o == exp_dvalid)
        else report_mismatch("p_data_valid_o", $sampled(exp_dvalid), $sampled(p_data_valid_o));
    a_pc: assert property (@(posedge clk) disable iff (!rst_n_i) p_pc_o == exp_pc)
        else report_mismatch("p_pc_o", $sampled(exp_pc), $sampled(p_pc_o));
    a_imm: assert property (@(posedge clk) disable iff (!rst_n_i) p_imm_o == exp_imm)
        else report_mismatch("p_imm_o", $sampled(exp_imm), $sampled(p_imm_o));
    a_ready: assert property (@(posedge clk) disable iff (!rst_n_i) d_ready_o == exp_ready)
        else report_mismatch("d_ready_o", $sampled(exp_ready), $sampled(d_ready_o));

    task automatic finish_run();
        $display("tests %0d, errors %0d", n_tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic step();
        @(posedge clk);
        c_retire_i  <= '0;
        d_valid_i   <= 1'b0;
        d_r_valid_i <= '0;
        c_flush_i   <= 1'b0;
    endtask

    task automatic drive_slot(input int s, input arf_id_t dst, input logic wreg,
                              input arf_id_t src_a, input arf_id_t src_b);
        d_warid_i[s]          <= dst;
        d_w_reg_i[s]          <= wreg;
        d_rarid_i[2*s]        <= src_a;
        d_rarid_i[2*s+1]      <= src_b;
        d_reg_need_i[2*s +: 2] <= 2'b11;
        d_pc_i[s]             <= $random(seed);
        d_imm_i[s]            <= $random(seed);
    endtask

    // retire the instruction that currently owns id in the spec table
    task automatic drive_retire(input int s, input arf_id_t id, input word_t data);
        c_retire_i[s]  <= 1'b1;
        c_w_valid_i[s] <= 1'b1;
        c_arf_id_i[s]  <= id;
        c_rob_id_i[s]  <= spec_m[id][ROB_ID_W-1:0];
        c_w_check_i[s] <= spec_m[id][CHECK_BIT];
        c_data_i[s]    <= data;
    endtask

    task automatic send(input logic [1:0] slots);
        d_valid_i   <= 1'b1;
        d_r_valid_i <= slots;
        ok = 1'b0;
        for (n = 0; n < TMO && !ok; n++) begin
            @(negedge clk);
            ok = d_ready_o;
            @(posedge clk);
            c_retire_i <= '0; // one retire per call
        end
        if (ok) begin
            d_valid_i   <= 1'b0;
            d_r_valid_i <= '0;
        end else begin
            $display("timeout: decode bundle never accepted at %0t", $time);
            errors++;
            finish_run();
        end
    endtask

    task automatic end_test(input string name);
        step();
        step();
        n_tests++;
        $display("test %0d %s: %0d errors", n_tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        seed = 76830;
        errors = 0;
        err_mark = 0;
        n_tests = 0;
        clk = 1'b0;
        rst_n_i = 1'b0;
        c_flush_i = 1'b0;
        d_valid_i = 1'b0;
        p_ready_i = 1'b1;
        d_r_valid_i = '0;
        d_w_reg_i = '0;
        d_reg_need_i = '0;
        d_rarid_i = '0;
        d_warid_i = '0;
        d_pc_i = '0;
        d_imm_i = '0;
        c_retire_i = '0;
        c_w_valid_i = '0;
        c_w_check_i = '0;
        c_arf_id_i = '0;
        c_rob_id_i = '0;
        c_data_i = '0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;

        step();
        p_ready_i <= 1'b0;
        step();
        p_ready_i <= 1'b1;
        drive_slot(0, 5'd0, 1'b0, 5'd7, 5'd9);
        drive_slot(1, 5'd0, 1'b0, 5'd12, 5'd0);
        send(2'b11);
        end_test("after reset");

        drive_slot(0, 5'd3, 1'b1, 5'd1, 5'd2);
        drive_slot(1, 5'd4, 1'b1, 5'd0, 5'd0);
        send(2'b11);
        drive_slot(0, 5'd8, 1'b1, 5'd3, 5'd4); // r3 r4 still in flight
        send(2'b01);
        step();
        drive_retire(0, 5'd3, 32'ha5a5_0003);
        step();
        drive_slot(0, 5'd0, 1'b0, 5'd3, 5'd4);
        send(2'b01);
        end_test("renaming");

        // same cycle retire and read
        drive_retire(0, 5'd4, 32'h1234_0004);
        drive_retire(1, 5'd8, 32'h5678_0008);
        drive_slot(0, 5'd0, 1'b0, 5'd4, 5'd8);
        send(2'b01);
        drive_slot(0, 5'd0, 1'b0, 5'd8, 5'd4);
        send(2'b01);
        end_test("retire");

        drive_slot(0, 5'd10, 1'b1, 5'd1, 5'd2);
        drive_slot(1, 5'd11, 1'b1, 5'd10, 5'd3);
        send(2'b11);
        drive_slot(0, 5'd0, 1'b1, 5'd0, 5'd0);
        drive_slot(1, 5'd12, 1'b1, 5'd0, 5'd10);
        send(2'b11);
        step();
        drive_retire(1, 5'd0, 32'hdead_beef);
        drive_slot(0, 5'd0, 1'b0, 5'd0, 5'd12);
        send(2'b01);
        end_test("intra-bundle bypass");

        p_ready_i <= 1'b0;
        drive_slot(0, 5'd13, 1'b1, 5'd3, 5'd4);
        drive_slot(1, 5'd14, 1'b1, 5'd13, 5'd8);
        d_valid_i   <= 1'b1;
        d_r_valid_i <= 2'b11;
        repeat (3) @(posedge clk);
        p_ready_i <= 1'b1;
        send(2'b11);
        end_test("back-pressure");

        ok = 1'b1;
        for (n = 0; n < 40 && ok; n++) begin
            @(posedge clk);
            drive_slot(0, arf_id_t'($random(seed)), 1'b1, arf_id_t'($random(seed)), 5'd3);
            drive_slot(1, arf_id_t'($random(seed)), 1'b1, arf_id_t'($random(seed)), 5'd4);
            d_valid_i   <= 1'b1;
            d_r_valid_i <= 2'b11;
            @(negedge clk);
            ok = d_ready_o;
        end
        if (ok) begin
            $display("ROB limit never stopped decode after %0d bundles", n);
            errors++;
        end
        @(posedge clk);
        c_flush_i <= 1'b1; // bundle still offered, must not issue
        step();
        for (int k = 0; k < ARF_DEPTH / 4; k++) begin
            drive_slot(0, 5'd0, 1'b0, arf_id_t'(4*k), arf_id_t'(4*k+1));
            drive_slot(1, 5'd0, 1'b0, arf_id_t'(4*k+2), arf_id_t'(4*k+3));
            send(2'b11);
        end
        end_test("ROB limit and flush");

        finish_run();
    end

endmodule

`default_nettype wire

// File: list.f
rtl/rename_pkg.sv
rtl/rename_if.sv
rtl/alloc_if.sv
rtl/rob_alloc.sv
rtl/spec_rat.sv
rtl/regfile_fwd.sv
rtl/rename_stage.sv
rtl/rename_top.sv
sim/tb_rename_top.sv

// File: Bender.yml
package:
  name: rename_stage

sources:
  - rtl/rename_pkg.sv
  - rtl/rename_if.sv
  - rtl/alloc_if.sv
  - rtl/rob_alloc.sv
  - rtl/spec_rat.sv
  - rtl/regfile_fwd.sv
  - rtl/rename_stage.sv
  - rtl/rename_top.sv
  - target: test
    files:
      - sim/tb_rename_top.sv
